/* Bender.yml */
package:
  name: pulse_unit

sources:
  - source/pulse_pkg.sv
  - source/pulse_cmd_decode.sv
  - source/pulse_fsm.sv
  - source/pulse_gen.sv
  - source/burst_result.sv
  - source/pulse_unit.sv
  - target: test
    files:
      - tests/pulse_checker.sv
      - tests/pulse_unit_tb.sv

/* source/burst_result.sv */
`timescale 1ns/1ns
`default_nettype none

module burst_result import pulse_pkg::*; (
	input logic clk,
	input logic reset,
	input logic burst_end,
	input logic reject_strobe,

	output logic burst_done,
	output logic [result_bits-1:0] bursts_finished,
	output logic cmd_reject
);

	always_ff @(posedge clk) begin
		if (reset) begin
			burst_done <= 0;
			cmd_reject <= 0;
			bursts_finished <= 0;
		end
		else begin
			burst_done <= burst_end;
			cmd_reject <= reject_strobe;
			// The new count shows in the same cycle as burst_done, wrapping at the top.
			if (burst_end) begin
				bursts_finished <= bursts_finished + 1'b1;
			end
		end
	end // always_ff

endmodule : burst_result

`default_nettype wire

/* source/pulse_cmd_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module pulse_cmd_decode import pulse_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input logic [opcode_bits-1:0] cmd_opcode,
	input cmd_payload_t cmd_payload,
	input logic busy,

	output logic [count_bits-1:0] pulse_num,
	output logic [width_bits-1:0] pulse_width,
	output logic [count_bits-1:0] burst_count,
	output logic [count_bits-1:0] idle_gap,
	output logic fire_strobe,
	output logic reject_strobe
);

	logic accept;

	// A FIRE that is still on its way to the FSM counts as busy too.
	assign accept = !busy & !fire_strobe;

	always_ff @(posedge clk) begin
		if (reset) begin
			fire_strobe <= 0;
			reject_strobe <= 0;
			pulse_num <= 0;
			pulse_width <= 0;
		end
		else begin
			fire_strobe <= 0;
			reject_strobe <= 0;
			if (cmd_valid) begin
				case (cmd_opcode)
					op_nop: ;
					op_config: begin
						if (accept) begin
							pulse_num <= cmd_payload.cfg.pulse_num;
							pulse_width <= cmd_payload.cfg.pulse_width;
						end
						else begin
							reject_strobe <= 1;
						end
					end
					op_fire: begin
						fire_strobe <= accept;
						reject_strobe <= !accept;
					end
					default: reject_strobe <= 1;
				endcase
			end
		end
	end // always_ff

	// Burst fields only matter from fire_strobe until the burst finishes.
	always_ff @(posedge clk) begin
		if (cmd_valid & (cmd_opcode == op_fire) & accept) begin
			burst_count <= cmd_payload.fire.burst_count;
			idle_gap <= cmd_payload.fire.idle_gap;
		end
	end // always_ff

endmodule : pulse_cmd_decode

`default_nettype wire

/* source/pulse_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module pulse_fsm import pulse_pkg::*; (
	input logic clk,
	input logic reset,
	input logic en,
	input logic fire_strobe,
	input logic [count_bits-1:0] burst_count,
	input logic [count_bits-1:0] idle_gap,
	input logic train_end,

	output logic train_start,
	output logic working,
	output logic busy,
	output logic burst_end
);

	logic [state_bits-1:0] state;
	logic [count_bits-1:0] trains_left;
	logic [count_bits-1:0] gap_cnt;
	logic [count_bits-1:0] gap_top;
	logic last_train;
	logic gap_done;
	logic back_to_back;

	assign gap_top = idle_gap - 1'b1;
	assign gap_done = gap_cnt == gap_top; // Only looked at while idle_gap is nonzero.
	assign last_train = trains_left == 1;
	assign back_to_back = train_end & !last_train & ~|idle_gap;

	// Loads the pulse counter in the cycle before each train begins.
	assign train_start = en & ((state == st_prepare) | ((state == st_gap) & gap_done) |
		((state == st_train) & back_to_back));

	assign burst_end = (state == st_train) & train_end & last_train;
	assign working = state == st_train;
	assign busy = state != st_idle;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			trains_left <= 0;
			gap_cnt <= 0;
		end
		else begin
			case (state)
				st_idle: begin
					// A command is taken even with en low; counting waits in prepare.
					if (fire_strobe) begin
						trains_left <= (|burst_count) ? burst_count : 1;
						state <= st_prepare;
					end
				end
				st_prepare: if (en) state <= st_train;
				st_train: begin
					if (train_end) begin
						gap_cnt <= 0;
						if (last_train) begin
							state <= st_finish;
						end
						else begin
							trains_left <= trains_left - 1'b1;
							if (|idle_gap) state <= st_gap;
						end
					end
				end
				st_gap: begin
					if (en) begin
						gap_cnt <= gap_cnt + 1'b1;
						if (gap_done) state <= st_train;
					end
				end
				st_finish: if (en) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end // always_ff

endmodule : pulse_fsm

`default_nettype wire

/* source/pulse_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module pulse_gen import pulse_pkg::*; (
	input logic clk,
	input logic reset,
	input logic en,
	input logic train_start,
	input logic working,
	input logic [count_bits-1:0] pulse_num,
	input logic [width_bits-1:0] pulse_width,

	output logic out,
	output logic train_end
);

	logic [count_bits-1:0] last_num;
	logic [width_bits-1:0] last_width;
	logic [count_bits-1:0] num_cnt;
	logic [width_bits:0] width_cnt; // One bit wider, a period is twice the width.

	logic [count_bits-1:0] num_top;
	logic [width_bits:0] width_top;
	logic zero_train;
	logic num_reached;
	logic width_reached;

	assign num_top = last_num - 1'b1;
	assign width_top = {last_width, 1'b0} - 1'b1;
	assign zero_train = (~|last_num) | (~|last_width);

	// With a zero count or width both targets count as reached at once.
	always_comb begin
		num_reached = num_cnt == num_top;
		width_reached = width_cnt == width_top;
		if (zero_train) begin
			num_reached = 1;
			width_reached = 1;
		end
	end // always_comb

	assign train_end = en & working & num_reached & width_reached;

	always_comb begin
		out = working & (width_cnt < {1'b0, last_width});
		if (zero_train) begin
			out = 0;
		end
	end // always_comb

	always_ff @(posedge clk) begin
		if (train_start) begin
			last_num <= pulse_num;
			last_width <= pulse_width;
		end
	end // always_ff

	always_ff @(posedge clk) begin
		if (reset) begin
			num_cnt <= 0;
			width_cnt <= 0;
		end
		else if (train_start) begin
			num_cnt <= 0;
			width_cnt <= 0;
		end
		else if (en & working) begin
			if (width_reached) begin
				width_cnt <= 0;
				if (num_reached) begin
					num_cnt <= 0;
				end
				else begin
					num_cnt <= num_cnt + 1'b1;
				end
			end
			else begin
				width_cnt <= width_cnt + 1'b1;
			end
		end
	end // always_ff

endmodule : pulse_gen

`default_nettype wire

/* source/pulse_pkg.sv */
`default_nettype none

package pulse_pkg;

	localparam int count_bits = 8;
	localparam int width_bits = 8;
	localparam int opcode_bits = 2;
	localparam int result_bits = 16;

	// Opcode 3 has no meaning and is refused by the decoder.
	localparam logic [opcode_bits-1:0] op_nop = 2'd0;
	localparam logic [opcode_bits-1:0] op_config = 2'd1;
	localparam logic [opcode_bits-1:0] op_fire = 2'd2;

	localparam int state_bits = 3;
	localparam logic [state_bits-1:0] st_idle = 3'd0;
	localparam logic [state_bits-1:0] st_prepare = 3'd1;
	localparam logic [state_bits-1:0] st_train = 3'd2;
	localparam logic [state_bits-1:0] st_gap = 3'd3;
	localparam logic [state_bits-1:0] st_finish = 3'd4;

	// The 16-bit payload under the opcode, read according to the opcode.
	typedef union packed {
		struct packed {
			logic [count_bits-1:0] pulse_num;
			logic [width_bits-1:0] pulse_width;
		} cfg;
		struct packed {
			logic [count_bits-1:0] burst_count;
			logic [count_bits-1:0] idle_gap;
		} fire;
	} cmd_payload_t;

endpackage : pulse_pkg

`default_nettype wire

/* source/pulse_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module pulse_unit import pulse_pkg::*; (
	input logic clk,
	input logic reset,
	input logic en,
	input logic cmd_valid,
	input logic [opcode_bits-1:0] cmd_opcode,
	input cmd_payload_t cmd_payload,

	output logic out,
	output logic busy,
	output logic burst_done,
	output logic [result_bits-1:0] bursts_finished,
	output logic cmd_reject
);

	logic [count_bits-1:0] pulse_num;
	logic [width_bits-1:0] pulse_width;
	logic [count_bits-1:0] burst_count;
	logic [count_bits-1:0] idle_gap;
	logic fire_strobe;
	logic reject_strobe;
	logic train_start;
	logic working;
	logic train_end;
	logic burst_end;

	pulse_cmd_decode decode (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_opcode(cmd_opcode),
		.cmd_payload(cmd_payload),
		.busy(busy),
		.pulse_num(pulse_num),
		.pulse_width(pulse_width),
		.burst_count(burst_count),
		.idle_gap(idle_gap),
		.fire_strobe(fire_strobe),
		.reject_strobe(reject_strobe)
	);

	pulse_fsm fsm (
		.clk(clk),
		.reset(reset),
		.en(en),
		.fire_strobe(fire_strobe),
		.burst_count(burst_count),
		.idle_gap(idle_gap),
		.train_end(train_end),
		.train_start(train_start),
		.working(working),
		.busy(busy),
		.burst_end(burst_end)
	);

	pulse_gen gen (
		.clk(clk),
		.reset(reset),
		.en(en),
		.train_start(train_start),
		.working(working),
		.pulse_num(pulse_num),
		.pulse_width(pulse_width),
		.out(out),
		.train_end(train_end)
	);

	burst_result result (
		.clk(clk),
		.reset(reset),
		.burst_end(burst_end),
		.reject_strobe(reject_strobe),
		.burst_done(burst_done),
		.bursts_finished(bursts_finished),
		.cmd_reject(cmd_reject)
	);

endmodule : pulse_unit

`default_nettype wire

/* tb.f */
source/pulse_pkg.sv
source/pulse_cmd_decode.sv
source/pulse_fsm.sv
source/pulse_gen.sv
source/burst_result.sv
source/pulse_unit.sv
tests/pulse_checker.sv
tests/pulse_unit_tb.sv

/* tests/pulse_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module pulse_checker import pulse_pkg::*; (
	input logic clk,
	input logic reset,
	input logic en,
	input logic out,
	input logic busy,
	input logic burst_done,
	input logic [result_bits-1:0] bursts_finished,
	input logic cmd_reject
);

	int errors = 0;
	int rejects = 0;
	int runs_q[$];
	int len_q[$];
	int gap_q[$];
	int per_train_q[$];
	int run = 0;
	int highs = 0;
	logic last_out = 0;
	logic [result_bits-1:0] done_count = 0;

	task automatic expect_burst(input int runs, input int run_len, input int gap_low,
		input int per_train);
		runs_q.push_back(runs);
		len_q.push_back(run_len);
		gap_q.push_back(gap_low);
		per_train_q.push_back(per_train);
	endtask

	task automatic compare(input string name, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic final_checks(input int expected_rejects);
		compare("cmd_reject count", rejects, expected_rejects);
		compare("bursts still pending", runs_q.size(), 0);
	endtask

	// Out only moves after a cycle with en high, so cycles with en low are skipped.
	always @(negedge clk) begin
		if (!reset && en) begin
			if (out !== last_out) begin
				if (runs_q.size() == 0) begin
					errors++;
					$display("Error at %0t: out changed while no burst was pending", $time);
				end
				else if (last_out) begin
					compare("out high run", run, len_q[0]);
				end
				else if (highs > 0) begin
					// Every N-th low run closes a train and includes the idle gap.
					compare("out low run", run,
						(highs % per_train_q[0] == 0) ? gap_q[0] : len_q[0]);
				end
				highs = highs + out;
				run = 0;
			end
			run++;
			last_out = out;
		end
		if (!reset && cmd_reject) begin
			rejects++;
		end
		if (!reset && burst_done) begin
			done_count = done_count + 1'b1;
			compare("bursts_finished", bursts_finished, done_count);
			// The unit stays busy through the finish cycle.
			compare("busy", busy, 1);
			if (runs_q.size() == 0) begin
				errors++;
				$display("Error at %0t: burst_done came with no burst pending", $time);
			end
			else begin
				compare("out high runs", highs, runs_q.pop_front());
				void'(len_q.pop_front());
				void'(gap_q.pop_front());
				void'(per_train_q.pop_front());
			end
			highs = 0;
		end
	end

endmodule : pulse_checker

`default_nettype wire

/* tests/pulse_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module pulse_unit_tb import pulse_pkg::*; ();

	logic clk = 0;
	logic reset = 1;
	logic en = 1;
	logic cmd_valid = 0;
	logic [opcode_bits-1:0] cmd_opcode = op_nop;
	cmd_payload_t cmd_payload = '0;
	logic out;
	logic busy;
	logic burst_done;
	logic [result_bits-1:0] bursts_finished;
	logic cmd_reject;
	integer seed = 32'hb33c;
	int timeouts = 0;
	int expected_rejects = 0;
	int rn;
	int rw;
	int rb;
	int rg;
	int rs;

	always #4 clk = ~clk;

	pulse_unit pulse_unit_inst (.*);

	pulse_checker check (.*);

	// Each train gives N pulses of W high and W low, and the gap adds to the last low.
	function automatic void reference_burst(input int n, input int w, input int b, input int g,
		output int runs, output int run_len, output int gap_low);
		int trains;
		trains = (b == 0) ? 1 : b;
		runs = (n == 0 || w == 0) ? 0 : trains * n;
		run_len = w;
		gap_low = w + g;
	endfunction

	task automatic send(input logic [opcode_bits-1:0] op, input logic [15:0] payload);
		cmd_valid = 1;
		cmd_opcode = op;
		cmd_payload = payload;
		@(posedge clk);
		#1;
		cmd_valid = 0;
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (busy && cycles < 200) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (busy) begin
			timeouts++;
			$display("Error at %0t: the DUT never left busy", $time);
		end
	endtask

	task automatic wait_burst(input bit stall);
		int cycles;
		int hold;
		cycles = 0;
		hold = 0;
		@(negedge clk);
		while (!burst_done && cycles < 2000) begin
			@(posedge clk);
			#1;
			en = !(stall && hold > 0);
			if (hold > 0)
				hold--;
			else if (stall && $random(seed) % 6 == 0)
				hold = 1 + $unsigned($random(seed)) % 5; // Length of the next pause.
			@(negedge clk);
			cycles++;
		end
		if (!burst_done) begin
			timeouts++;
			$display("Error at %0t: the burst never finished", $time);
		end
		@(posedge clk);
		#1;
		en = 1;
	endtask

	task automatic measure_rise(output int cycles);
		cycles = 0;
		while (!out && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic run_burst(input int n, input int w, input int b, input int g,
		input bit stall, input int mode);
		int runs;
		int run_len;
		int gap_low;
		int rise;
		wait_idle();
		send(op_config, {n[7:0], w[7:0]});
		reference_burst(n, w, b, g, runs, run_len, gap_low);
		check.expect_burst(runs, run_len, gap_low, (n == 0) ? 1 : n);
		send(op_fire, {b[7:0], g[7:0]});
		if (mode == 1) begin
			measure_rise(rise);
			check.compare("out rise latency", rise, 3);
		end
		if (mode == 2) begin
			send(op_config, 16'h0101);
			send(op_fire, 16'h0000);
			send(2'd3, 16'hffff);
			send(op_nop, 16'h0000); // Ignored, no reject.
			expected_rejects += 3;
		end
		wait_burst(stall);
	endtask

	initial begin
		repeat (8) @(posedge clk);
		#1;
		reset = 0;
		run_burst(3, 2, 1, 0, 0, 1);
		run_burst(2, 3, 3, 4, 0, 0);
		run_burst(2, 1, 4, 0, 0, 0);
		run_burst(0, 4, 2, 3, 0, 0);
		run_burst(3, 0, 1, 2, 0, 0);
		run_burst(3, 4, 2, 5, 0, 2);
		send(2'd3, 16'h1234);
		expected_rejects += 1;
		run_burst(2, 3, 3, 2, 1, 0);
		run_burst(4, 2, 0, 3, 1, 0);
		for (int i = 0; i < 12; i++) begin
			rn = $unsigned($random(seed)) % 4;
			rw = $unsigned($random(seed)) % 4;
			rb = $unsigned($random(seed)) % 4;
			rg = $unsigned($random(seed)) % 4;
			rs = $unsigned($random(seed)) % 2;
			run_burst(rn, rw, rb, rg, rs[0], 0);
		end
		repeat (4) @(posedge clk);
		check.final_checks(expected_rejects);
		$display("Errors: %0d mismatches, %0d timeouts", check.errors, timeouts);
		if (check.errors == 0 && timeouts == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule : pulse_unit_tb

`default_nettype wire
